/* mem_test_pkg.sv */
// Shared sizes, encodings and bus structs; burst codes above BL16 act as BL16.
package mem_test_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int ADDR_W    = 22;
  localparam int DATA_W    = 16;
  localparam int MAX_BURST = 16;
  localparam int BCNT_W    = 5;
  localparam int IDX_W     = $clog2(MAX_BURST);
  localparam int APB_AW    = 8;
  localparam int APB_DW    = 32;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  localparam logic [APB_AW-1:0] REG_CTRL     = 8'h00;
  localparam logic [APB_AW-1:0] REG_CONFIG   = 8'h04;
  localparam logic [APB_AW-1:0] REG_REGION   = 8'h08;
  localparam logic [APB_AW-1:0] REG_STATUS   = 8'h0C;
  localparam logic [APB_AW-1:0] REG_ERR_ADDR = 8'h10;
  localparam logic [APB_AW-1:0] REG_ERR_DATA = 8'h14;
  localparam logic [APB_AW-1:0] REG_BURSTS   = 8'h18;

  typedef enum logic [2:0] {BL1, BL2, BL4, BL8, BL16} burst_len_e;

  typedef enum logic [3:0] {
    IDLE, FILL, WR_CMD, WR_BEAT, RD_CMD, RD_WAIT, CMP, DONE, ERR
  } tester_state_e;

  typedef struct packed {
    logic              read;
    logic              write;
    logic [ADDR_W-1:0] address;
    logic [BCNT_W-1:0] burstcount;
    logic [DATA_W-1:0] writedata;
  } mem_req_t;

  typedef struct packed {
    logic              waitrequest;
    logic              readdatavalid;
    logic [DATA_W-1:0] readdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [DATA_W-1:0] seed;
    burst_len_e        burst_len;
    logic [ADDR_W-1:0] region_words;
  } test_cfg_t;

  typedef struct packed {
    logic              busy;
    logic              done;
    logic              error;
    logic [ADDR_W-1:0] err_addr;
    logic [DATA_W-1:0] err_exp;
    logic [DATA_W-1:0] err_act;
    logic [ADDR_W-1:0] bursts_done;
  } test_stat_t;

  // Words per burst for a length code.
  function automatic logic [BCNT_W-1:0] burst_words(input burst_len_e bl);
    case (bl)
      BL1:     return BCNT_W'(1);
      BL2:     return BCNT_W'(2);
      BL4:     return BCNT_W'(4);
      BL8:     return BCNT_W'(8);
      default: return BCNT_W'(MAX_BURST);
    endcase
  endfunction

endpackage

/* apb_regs.sv */
// APB slave, pready tied high; unmapped offsets flag pslverr, read 0 and drop writes.
`timescale 1ns/1ps

module apb_regs
  import mem_test_pkg::*;
(
  input  logic              w_clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  input  test_stat_t        stat,
  output test_cfg_t         cfg,
  output logic              start
);

  test_cfg_t cfg_q;
  logic      access;
  logic      wr_access;
  logic      mapped;

  assign access    = psel & penable;
  assign wr_access = access & pwrite & mapped;

  always_comb begin
    case (paddr)
      REG_CTRL, REG_CONFIG, REG_REGION, REG_STATUS,
      REG_ERR_ADDR, REG_ERR_DATA, REG_BURSTS: mapped = 1'b1;
      default:                                mapped = 1'b0;
    endcase
  end

  assign pready  = 1'b1;                 // No wait states.
  assign pslverr = access & ~mapped;

  // ------------------------------------------------------------
  // Config registers and start pulse
  // ------------------------------------------------------------
  always_ff @(posedge w_clk) begin
    if (!rst_n) begin
      cfg_q.seed         <= '0;
      cfg_q.burst_len    <= BL1;
      cfg_q.region_words <= '0;
      start              <= 1'b0;
    end else begin
      start <= wr_access & (paddr == REG_CTRL) & pwdata[0] & ~stat.busy;
      if (wr_access && paddr == REG_CONFIG) begin
        cfg_q.seed      <= pwdata[31:16];
        cfg_q.burst_len <= burst_len_e'(pwdata[2:0]);   // Codes 5..7 kept as written.
      end
      if (wr_access && paddr == REG_REGION) begin
        cfg_q.region_words <= pwdata[ADDR_W-1:0];
      end
    end
  end

  assign cfg = cfg_q;

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (paddr)
        REG_CONFIG: begin
          prdata[31:16] = cfg_q.seed;
          prdata[2:0]   = cfg_q.burst_len;
        end
        REG_REGION:   prdata[ADDR_W-1:0] = cfg_q.region_words;
        REG_STATUS:   prdata[2:0]        = {stat.error, stat.done, stat.busy};
        REG_ERR_ADDR: prdata[ADDR_W-1:0] = stat.err_addr;
        REG_ERR_DATA: prdata             = {stat.err_exp, stat.err_act};
        REG_BURSTS:   prdata[ADDR_W-1:0] = stat.bursts_done;
        default:      prdata             = '0;    // CTRL reads as zero.
      endcase
    end
  end

endmodule

/* burst_tester.sv */
// Burst fill/write/read/compare tester; one burst outstanding, no timeout on a stalled memory.
`timescale 1ns/1ps

module burst_tester
  import mem_test_pkg::*;
(
  input  logic       w_clk,
  input  logic       rst_n,
  input  test_cfg_t  cfg,
  input  logic       start,
  output mem_req_t   mem_req,
  input  mem_rsp_t   mem_rsp,
  output test_stat_t stat
);

  tester_state_e state;

  logic [DATA_W-1:0] wr_buf [MAX_BURST];
  logic [DATA_W-1:0] rd_buf [MAX_BURST];

  logic [DATA_W-1:0] seed_q;
  logic [BCNT_W-1:0] blen;                // Words per burst for this run.
  logic [BCNT_W-1:0] idx;
  logic [ADDR_W:0]   base;                // One spare bit so the end can be reached.
  logic [ADDR_W:0]   limit;
  logic              rd_q;
  logic              wr_q;
  logic [ADDR_W-1:0] bursts;
  logic [ADDR_W-1:0] err_addr;
  logic [DATA_W-1:0] err_exp;
  logic [DATA_W-1:0] err_act;

  logic              busy;
  logic              last;
  logic [IDX_W-1:0]  slot;
  logic [ADDR_W-1:0] cur_addr;
  logic [ADDR_W:0]   base_next;
  logic [BCNT_W-1:0] start_blen;
  logic [ADDR_W:0]   start_mask;
  logic [ADDR_W:0]   start_limit;

  assign busy      = (state != IDLE) && (state != DONE) && (state != ERR);
  assign last      = (idx == blen - 1'b1);
  assign slot      = idx[IDX_W-1:0];
  assign cur_addr  = base[ADDR_W-1:0] + ADDR_W'(idx);
  assign base_next = base + (ADDR_W+1)'(blen);

  // Region rounded up to a whole burst; burst sizes are powers of two.
  assign start_blen  = burst_words(cfg.burst_len);
  assign start_mask  = (ADDR_W+1)'(start_blen) - 1'b1;
  assign start_limit = ({1'b0, cfg.region_words} + start_mask) & ~start_mask;

  // ------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------
  always_ff @(posedge w_clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      rd_q     <= 1'b0;
      wr_q     <= 1'b0;
      idx      <= '0;
      base     <= '0;
      limit    <= '0;
      blen     <= BCNT_W'(1);
      seed_q   <= '0;
      bursts   <= '0;
      err_addr <= '0;
      err_exp  <= '0;
      err_act  <= '0;
    end else if (start && !busy) begin
      seed_q   <= cfg.seed;
      blen     <= start_blen;
      limit    <= start_limit;
      base     <= '0;
      idx      <= '0;
      bursts   <= '0;
      err_addr <= '0;
      err_exp  <= '0;
      err_act  <= '0;
      state    <= (cfg.region_words == '0) ? DONE : FILL;   // Empty region touches no memory.
    end else begin
      case (state)
        FILL: begin
          if (last) begin
            idx   <= '0;
            state <= WR_CMD;
          end else begin
            idx <= idx + 1'b1;
          end
        end

        WR_CMD: begin
          wr_q  <= 1'b1;
          idx   <= '0;
          state <= WR_BEAT;
        end

        WR_BEAT: begin
          if (!mem_rsp.waitrequest) begin
            if (last) begin
              wr_q  <= 1'b0;
              rd_q  <= 1'b1;                  // Read command follows the last beat.
              idx   <= '0;
              state <= RD_CMD;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end

        RD_CMD: begin
          if (!mem_rsp.waitrequest) begin
            rd_q  <= 1'b0;
            state <= RD_WAIT;
          end
        end

        RD_WAIT: begin
          if (mem_rsp.readdatavalid) begin
            if (last) begin
              idx   <= '0;
              state <= CMP;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end

        CMP: begin
          if (rd_buf[slot] != wr_buf[slot]) begin
            err_addr <= cur_addr;
            err_exp  <= wr_buf[slot];
            err_act  <= rd_buf[slot];
            state    <= ERR;
          end else if (last) begin
            idx    <= '0;
            bursts <= bursts + 1'b1;
            base   <= base_next;
            state  <= (base_next >= limit) ? DONE : FILL;
          end else begin
            idx <= idx + 1'b1;
          end
        end

        default: ;                            // IDLE, DONE, ERR wait for start.
      endcase
    end
  end

  // ------------------------------------------------------------
  // Buffers
  // ------------------------------------------------------------
  always_ff @(posedge w_clk) begin
    if (state == FILL) begin
      wr_buf[slot] <= seed_q + cur_addr[DATA_W-1:0];   // Pattern wraps at 16 bits.
    end
    if (state == RD_WAIT && mem_rsp.readdatavalid) begin
      rd_buf[slot] <= mem_rsp.readdata;
    end
  end

  assign mem_req.read       = rd_q;
  assign mem_req.write      = wr_q;
  assign mem_req.address    = base[ADDR_W-1:0];
  assign mem_req.burstcount = blen;
  assign mem_req.writedata  = wr_buf[slot];   // Beat index advances only on accepted beats.

  assign stat.busy        = busy;
  assign stat.done        = (state == DONE);
  assign stat.error       = (state == ERR);
  assign stat.err_addr    = err_addr;
  assign stat.err_exp     = err_exp;
  assign stat.err_act     = err_act;
  assign stat.bursts_done = bursts;

endmodule

/* mem_test_top.sv */
// Memory tester top; the burst memory is external and must follow the Avalon burst handshake.
`timescale 1ns/1ps

module mem_test_top
  import mem_test_pkg::*;
(
  input  logic              w_clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  output mem_req_t          mem_req,
  input  mem_rsp_t          mem_rsp
);

  test_cfg_t  cfg;
  test_stat_t stat;
  logic       start;

  // ------------------------------------------------------------
  // Register block
  // ------------------------------------------------------------
  apb_regs regs0 (
    .w_clk   (w_clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .stat    (stat),
    .cfg     (cfg),
    .start   (start)
  );

  // ------------------------------------------------------------
  // Tester
  // ------------------------------------------------------------
  burst_tester tester0 (
    .w_clk   (w_clk),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .start   (start),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .stat    (stat)
  );

endmodule

/* tb_mem_model.sv */
// Testbench burst memory of 1024 words; addresses wrap, one outstanding read, optional bit-0 fault.
`timescale 1ns/1ps

module tb_mem_model
  import mem_test_pkg::*;
(
  input  logic              w_clk,
  input  logic              rst_n,
  input  mem_req_t          mem_req,
  output mem_rsp_t          mem_rsp,
  input  logic              fault_en,
  input  logic [ADDR_W-1:0] fault_addr
);

  localparam int MEM_AW = 10;

  logic [DATA_W-1:0] mem [2**MEM_AW];
  mem_rsp_t          rsp_q = '0;
  logic [BCNT_W-1:0] wr_beat;
  logic [BCNT_W-1:0] rd_left;             // Read beats still owed.
  logic [ADDR_W-1:0] rd_addr;
  int                rd_delay;

  assign mem_rsp = rsp_q;

  // ------------------------------------------------------------
  // Command side, sampled on the rising edge
  // ------------------------------------------------------------
  always @(posedge w_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**MEM_AW; i++) begin
        mem[i] <= 16'(i) ^ 16'hA5C3;
      end
      wr_beat  <= '0;
      rd_left  <= '0;
      rd_addr  <= '0;
      rd_delay <= 0;
    end else begin
      if (mem_req.write && !mem_rsp.waitrequest) begin
        mem[MEM_AW'(mem_req.address + ADDR_W'(wr_beat))] <= mem_req.writedata;
        wr_beat <= (wr_beat == mem_req.burstcount - 1'b1) ? '0 : wr_beat + 1'b1;
      end
      if (mem_req.read && !mem_rsp.waitrequest) begin
        rd_left  <= mem_req.burstcount;
        rd_addr  <= mem_req.address;
        rd_delay <= int'($urandom % 32'd4);   // Latency of 1 to 4 cycles.
      end else if (mem_rsp.readdatavalid) begin
        rd_left <= rd_left - 1'b1;
        rd_addr <= rd_addr + 1'b1;
      end else if (rd_delay > 0) begin
        rd_delay <= rd_delay - 1;
      end
    end
  end

  // ------------------------------------------------------------
  // Response side, driven on the falling edge
  // ------------------------------------------------------------
  always @(negedge w_clk) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else begin
      rsp_q.waitrequest   <= ($urandom % 32'd10) < 32'd3;   // About 30 percent.
      rsp_q.readdatavalid <= 1'b0;
      if (rd_left != '0 && rd_delay == 0 && ($urandom % 32'd3) != 32'd0) begin
        rsp_q.readdatavalid <= 1'b1;
        rsp_q.readdata      <= mem[MEM_AW'(rd_addr)] ^
                               {15'd0, fault_en && (rd_addr == fault_addr)};
      end
    end
  end

endmodule

/* tb_mem_test.sv */
// Testbench for the memory tester; the memory model wraps at 1024 words, so regions stay small.
`timescale 1ns/1ps

module tb_mem_test
  import mem_test_pkg::*;
;

  localparam logic [31:0] SEED       = 32'hce39_c1b3;
  localparam int          CLK_HALF   = 10;
  localparam int          APB_LIMIT  = 16;
  localparam int          POLL_LIMIT = 2000;

  typedef struct packed {
    logic [DATA_W-1:0] seed;
    logic [2:0]        code;
    logic [ADDR_W-1:0] region;
    logic              fault_en;
    logic [ADDR_W-1:0] fault_addr;
    logic              exp_err;          // Run is expected to end in error.
  } row_t;

  logic              w_clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  mem_req_t          mem_req;
  mem_rsp_t          mem_rsp;
  logic              fault_en;
  logic [ADDR_W-1:0] fault_addr;

  row_t  rows[$];
  string names[$];

  mem_test_top dut0 (.*);
  tb_mem_model mem0 (.*);

  initial begin
    w_clk = 1'b0;
    forever #(CLK_HALF) w_clk = ~w_clk;
  end

  task automatic check_equal(input string test, input string what,
                             input logic [APB_DW-1:0] expected, input logic [APB_DW-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected 0x%08h actual 0x%08h", test, what, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not finish in time", what);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  endtask

  // ------------------------------------------------------------
  // APB master
  // ------------------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata,
                          output logic [APB_DW-1:0] rdata, output logic err);
    int waits;
    waits = 0;
    @(negedge w_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge w_clk);
    penable = 1'b1;
    #(CLK_HALF - 1);                     // Just before the edge that ends the access.
    while (!pready) begin
      if (waits == APB_LIMIT) report_timeout("APB transfer");
      waits++;
      @(negedge w_clk);
      #(CLK_HALF - 1);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge w_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_xfer(1'b1, addr, data, rd, err);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] rdata,
                          output logic err);
    apb_xfer(1'b0, addr, '0, rdata, err);
  endtask

  // Burst length code to words; codes above BL16 clamp to 16.
  function automatic logic [ADDR_W-1:0] words_per_burst(input logic [2:0] code);
    if (code >= 3'd4) return ADDR_W'(MAX_BURST);
    return ADDR_W'(1) << code;
  endfunction

  task automatic add_row(input string name, input logic [DATA_W-1:0] seed, input logic [2:0] code,
                         input logic [ADDR_W-1:0] region, input logic fen,
                         input logic [ADDR_W-1:0] faddr, input logic exp_err);
    names.push_back(name);
    rows.push_back('{seed, code, region, fen, faddr, exp_err});
  endtask

  task automatic fill_table();
    add_row("clean_bl16",    16'h1234, 3'd4, 22'd256, 1'b0, 22'd0,   1'b0);
    add_row("fault37_bl8",   16'hBEEF, 3'd3, 22'd128, 1'b1, 22'd37,  1'b1);
    add_row("rerun_bl8",     16'hBEEF, 3'd3, 22'd128, 1'b0, 22'd37,  1'b0);
    add_row("bl1",           16'h0001, 3'd0, 22'd64,  1'b0, 22'd0,   1'b0);
    add_row("bl2_wrap",      16'hFFF0, 3'd1, 22'd64,  1'b0, 22'd0,   1'b0);
    add_row("bl4",           16'h5A5A, 3'd2, 22'd64,  1'b0, 22'd0,   1'b0);
    add_row("code7_clamp",   16'h0F0F, 3'd7, 22'd64,  1'b0, 22'd0,   1'b0);
    add_row("region0",       16'h2222, 3'd3, 22'd0,   1'b0, 22'd0,   1'b0);
    add_row("odd_region",    16'h3C3C, 3'd3, 22'd50,  1'b0, 22'd0,   1'b0);
    add_row("fault200_bl16", 16'h7777, 3'd4, 22'd256, 1'b1, 22'd200, 1'b1);
  endtask

  task automatic check_apb_map();
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_read(REG_CONFIG, rd, err);
    check_equal("apb_map", "CONFIG after reset", 32'd0, rd);
    apb_read(REG_REGION, rd, err);
    check_equal("apb_map", "REGION after reset", 32'd0, rd);
    apb_read(REG_BURSTS, rd, err);
    check_equal("apb_map", "BURSTS after reset", 32'd0, rd);
    apb_write(REG_STATUS, 32'h0000_0007);
    apb_read(REG_STATUS, rd, err);
    check_equal("apb_map", "STATUS after write", 32'd0, rd);
    check_equal("apb_map", "PSLVERR on STATUS", 32'd0, {31'd0, err});
    apb_read(8'h1C, rd, err);
    check_equal("apb_map", "PSLVERR read 0x1C", 32'd1, {31'd0, err});
    check_equal("apb_map", "PRDATA read 0x1C", 32'd0, rd);
    apb_xfer(1'b1, 8'h40, 32'hFFFF_FFFF, rd, err);
    check_equal("apb_map", "PSLVERR write 0x40", 32'd1, {31'd0, err});
  endtask

  // ------------------------------------------------------------
  // One table row
  // ------------------------------------------------------------
  task automatic run_row(input string name, input row_t r);
    logic [APB_DW-1:0] rd;
    logic [APB_DW-1:0] status;
    logic              err;
    logic [ADDR_W-1:0] blw;
    logic [ADDR_W-1:0] span;
    logic [ADDR_W-1:0] exp_bursts;
    logic [DATA_W-1:0] exp_word;
    int                polls;
    blw        = words_per_burst(r.code);
    span       = ((r.region + blw - 1'b1) / blw) * blw;
    exp_bursts = r.exp_err ? r.fault_addr / blw : span / blw;
    exp_word   = r.seed + r.fault_addr[DATA_W-1:0];
    @(negedge w_clk);
    fault_en   = r.fault_en;
    fault_addr = r.fault_addr;
    apb_write(REG_CONFIG, {r.seed, 13'd0, r.code});
    apb_write(REG_REGION, {10'd0, r.region});
    apb_read(REG_CONFIG, rd, err);
    check_equal(name, "CONFIG", {r.seed, 13'd0, r.code}, rd);
    check_equal(name, "PSLVERR on CONFIG", 32'd0, {31'd0, err});
    apb_read(REG_REGION, rd, err);
    check_equal(name, "REGION", {10'd0, r.region}, rd);
    apb_write(REG_CTRL, 32'd1);
    apb_read(REG_STATUS, status, err);
    if (r.region != '0) begin
      check_equal(name, "STATUS busy", 32'd1, status);
      apb_write(REG_CONFIG, {~r.seed, 13'd0, r.code});   // A restart would pick up this seed.
      apb_write(REG_CTRL, 32'd1);        // Must be dropped while busy.
    end
    polls = 0;
    while (status[2:1] == 2'b00) begin
      if (polls == POLL_LIMIT) report_timeout({"test ", name});
      polls++;
      apb_read(REG_STATUS, status, err);
    end
    check_equal(name, "STATUS", r.exp_err ? 32'd4 : 32'd2, status);
    apb_read(REG_ERR_ADDR, rd, err);
    check_equal(name, "ERR_ADDR", r.exp_err ? {10'd0, r.fault_addr} : 32'd0, rd);
    apb_read(REG_ERR_DATA, rd, err);
    check_equal(name, "ERR_DATA", r.exp_err ? {exp_word, exp_word ^ 16'h0001} : 32'd0, rd);
    apb_read(REG_BURSTS, rd, err);
    check_equal(name, "BURSTS", {10'd0, exp_bursts}, rd);
    if (!r.exp_err) begin
      for (int a = 0; a < int'(span); a++) begin
        check_equal(name, "MEM", {16'd0, r.seed + 16'(a)}, {16'd0, mem0.mem[a]});
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    fault_en   = 1'b0;
    fault_addr = '0;
    fill_table();
    repeat (10) @(negedge w_clk);
    rst_n = 1'b1;
    check_apb_map();
    foreach (rows[i]) begin
      run_row(names[i], rows[i]);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* project.f */
mem_test_pkg.sv
apb_regs.sv
burst_tester.sv
mem_test_top.sv
tb_mem_model.sv
tb_mem_test.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_test
SIM_DIR   ?= obj_dir
FILELIST  ?= project.f
PASS_MSG  ?= Simulation PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

$(SIM_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the simulator output.
sim: $(SIM_DIR)/V$(TOP)
	@out="$$(./$(SIM_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(SIM_DIR)
